// File: verilog/corr_defs.svh
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// Antenna sign-bit lanes in one sample
`define CORR_ANTENNAS 24

// Pairs in the walk table, one pair per clock
`define CORR_SLOTS 12

// Signed width of each cosine and sine accumulator
`define CORR_ACCUM_BITS 12

// Readout credits the consumer holds out of reset
`define CORR_CREDITS 4

// Pair table, ten bits per entry, slot 0 in the low bits
// Entry layout is {b[4:0], a[4:0]}
// Antennas 0 and 1 crossed with antennas 6 to 11
`define CORR_PAIR_TABLE {10'h161, 10'h141, 10'h121, 10'h101, \
                         10'h0e1, 10'h0c1, 10'h160, 10'h140, \
                         10'h120, 10'h100, 10'h0e0, 10'h0c0}

`endif

// File: verilog/corr_pkg.sv
`include "corr_defs.svh"

package corr_pkg;

   // ---------------------------------------------------------------------
   // Indices
   // ---------------------------------------------------------------------
   // Slot number in the pair walk, 0 to CORR_SLOTS-1
   typedef logic [3:0] slot_t;

   // Antenna lane number, room for 32 lanes
   typedef logic [4:0] ant_idx_t;

   // One decoded table entry
   // Antenna a in the low five bits, as packed in the table
   typedef struct packed {
      ant_idx_t b;
      ant_idx_t a;
   } pair_t;

   // ---------------------------------------------------------------------
   // Accumulators
   // ---------------------------------------------------------------------
   // Wrapping two's complement count
   typedef logic signed [`CORR_ACCUM_BITS-1:0] accum_t;

   // One visibility, cosine in the upper half
   typedef struct packed {
      accum_t cos_acc;
      accum_t sin_acc;
   } vis_t;

   // Readout credits, 0 to CORR_CREDITS
   typedef logic [2:0] credit_t;

endpackage

// File: verilog/pair_decode.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module pair_decode (
   input  logic                      clk_x,
   input  logic                      rst_n,
   input  logic                      sample_valid,
   input  logic [`CORR_ANTENNAS-1:0] sample_re,
   input  logic [`CORR_ANTENNAS-1:0] sample_im,
   input  logic                      hold,
   output logic                      sample_ready,
   output logic                      step_valid,
   output corr_pkg::slot_t           step_slot,
   output logic                      step_ar,
   output logic                      step_br,
   output logic                      step_bi
);
   import corr_pkg::*;

   localparam int    PAIR_W    = $bits(pair_t);
   localparam logic [PAIR_W*`CORR_SLOTS-1:0] PAIR_TABLE = `CORR_PAIR_TABLE;
   localparam slot_t LAST_SLOT = slot_t'(`CORR_SLOTS - 1);

   logic                      busy;
   slot_t                     slot_cnt;
   logic                      last_slot;
   logic                      accept;
   logic [`CORR_ANTENNAS-1:0] samp_re;
   logic [`CORR_ANTENNAS-1:0] samp_im;
   pair_t                     cur_pair;

   // Ready already during the last slot, so samples can follow back to back
   assign last_slot    = (slot_cnt == LAST_SLOT);
   assign sample_ready = ~hold & (~busy | last_slot);
   assign accept       = sample_valid & sample_ready;

   // Slot walker
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         slot_cnt <= '0;
      end else if (accept) begin
         busy     <= 1'b1;
         slot_cnt <= '0;
      end else if (busy) begin
         busy     <= ~last_slot;
         slot_cnt <= last_slot ? '0 : slot_t'(slot_cnt + 1'b1);
      end
   end

   // Sample held for the whole walk
   always_ff @(posedge clk_x) begin
      if (accept) begin
         samp_re <= sample_re;
         samp_im <= sample_im;
      end
   end

   // Table lookup for the current slot
   assign cur_pair = PAIR_TABLE[slot_cnt*PAIR_W +: PAIR_W];

   // Step strobe
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n)
         step_valid <= 1'b0;
      else
         step_valid <= busy;
   end

   // Selected sign bits, real of a, real and imag of b
   always_ff @(posedge clk_x) begin
      step_slot <= slot_cnt;
      step_ar   <= samp_re[cur_pair.a];
      step_br   <= samp_re[cur_pair.b];
      step_bi   <= samp_im[cur_pair.b];
   end

endmodule

// File: verilog/correlate_execute.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module correlate_execute (
   input  logic            clk_x,
   input  logic            rst_n,
   input  logic            step_valid,
   input  corr_pkg::slot_t step_slot,
   input  logic            step_ar,
   input  logic            step_br,
   input  logic            step_bi,
   input  corr_pkg::vis_t  prior_data,
   input  logic            prior_fresh,
   output logic            upd_valid,
   output corr_pkg::slot_t upd_slot,
   output corr_pkg::vis_t  upd_data,
   output logic            upd_wrap_cos,
   output logic            upd_wrap_sin
);
   import corr_pkg::*;

   localparam int ACC_W = `CORR_ACCUM_BITS;

   // Add +1 on agreement, -1 otherwise
   // Result is {wrap, sum}
   function automatic logic [ACC_W:0] add_sign(input accum_t base, input logic agree);
      logic [ACC_W:0] term;
      logic [ACC_W:0] wide;
      term = agree ? {{ACC_W{1'b0}}, 1'b1} : {(ACC_W+1){1'b1}};
      wide = {base[ACC_W-1], base} + term;
      // Extra bit disagrees with the sign bit only on a wrap
      return {wide[ACC_W] ^ wide[ACC_W-1], wide[ACC_W-1:0]};
   endfunction

   accum_t         base_cos;
   accum_t         base_sin;
   logic           cos_agree;
   logic           sin_agree;
   logic [ACC_W:0] res_cos;
   logic [ACC_W:0] res_sin;

   // ---------------------------------------------------------------------
   // Terms and sums
   // ---------------------------------------------------------------------
   // Fresh slot starts again from zero
   assign base_cos = prior_fresh ? '0 : prior_data.cos_acc;
   assign base_sin = prior_fresh ? '0 : prior_data.sin_acc;

   // Cosine: re(a) vs re(b)
   assign cos_agree = ~(step_ar ^ step_br);
   // Sine: re(a) vs im(b)
   assign sin_agree = ~(step_ar ^ step_bi);

   assign res_cos = add_sign(base_cos, cos_agree);
   assign res_sin = add_sign(base_sin, sin_agree);

   // ---------------------------------------------------------------------
   // Update register
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n)
         upd_valid <= 1'b0;
      else
         upd_valid <= step_valid;
   end

   always_ff @(posedge clk_x) begin
      if (step_valid) begin
         upd_slot         <= step_slot;
         upd_data.cos_acc <= res_cos[ACC_W-1:0];
         upd_data.sin_acc <= res_sin[ACC_W-1:0];
         upd_wrap_cos     <= res_cos[ACC_W];
         upd_wrap_sin     <= res_sin[ACC_W];
      end
   end

endmodule

// File: verilog/visibility_result.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module visibility_result (
   input  logic            clk_x,
   input  logic            rst_n,
   input  corr_pkg::slot_t step_slot,
   output corr_pkg::vis_t  prior_data,
   output logic            prior_fresh,
   input  logic            upd_valid,
   input  corr_pkg::slot_t upd_slot,
   input  corr_pkg::vis_t  upd_data,
   input  logic            upd_wrap_cos,
   input  logic            upd_wrap_sin,
   input  logic            pipe_busy,
   input  logic            bank_switch,
   output logic            hold,
   input  logic            vis_credit,
   output logic            vis_valid,
   output corr_pkg::slot_t vis_slot,
   output corr_pkg::vis_t  vis_data,
   output logic            vis_overflow_cos,
   output logic            vis_overflow_sin
);
   import corr_pkg::*;

   localparam int    SLOTS     = `CORR_SLOTS;
   localparam slot_t LAST_SLOT = slot_t'(SLOTS - 1);

   // Two banks, indexed by bank then slot
   vis_t             acc_mem [2][SLOTS];
   logic [SLOTS-1:0] fresh   [2];

   logic    act_bank;
   logic    idle_bank;
   logic    ovf_cos;
   logic    ovf_sin;
   logic    switch_pend;
   logic    take;
   logic    rd_active;
   slot_t   rd_slot;
   credit_t credit_cnt;
   logic    send;
   vis_t    rd_word;

   assign idle_bank = ~act_bank;

   // ---------------------------------------------------------------------
   // Accumulate side, active bank
   // ---------------------------------------------------------------------
   assign prior_data  = acc_mem[act_bank][step_slot];
   assign prior_fresh = fresh[act_bank][step_slot];

   always_ff @(posedge clk_x) begin
      if (upd_valid)
         acc_mem[act_bank][upd_slot] <= upd_data;
   end

   // Idle bank turns fresh as it becomes active
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         fresh[0] <= '1;
         fresh[1] <= '1;
      end else if (take) begin
         fresh[idle_bank] <= '1;
      end else if (upd_valid) begin
         fresh[act_bank][upd_slot] <= 1'b0;
      end
   end

   // ---------------------------------------------------------------------
   // Bank switch and overflow flags
   // ---------------------------------------------------------------------
   // Request blocks new samples at once, even before it is registered
   assign hold = switch_pend | bank_switch;
   assign take = switch_pend & ~pipe_busy & ~rd_active;

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         switch_pend      <= 1'b0;
         act_bank         <= 1'b0;
         ovf_cos          <= 1'b0;
         ovf_sin          <= 1'b0;
         vis_overflow_cos <= 1'b0;
         vis_overflow_sin <= 1'b0;
      end else begin
         switch_pend <= bank_switch | (switch_pend & ~take);
         if (take) begin
            act_bank <= idle_bank;
            // Flags of the bank now frozen go out with its readout
            vis_overflow_cos <= ovf_cos;
            vis_overflow_sin <= ovf_sin;
            ovf_cos          <= 1'b0;
            ovf_sin          <= 1'b0;
         end else if (upd_valid) begin
            ovf_cos <= ovf_cos | upd_wrap_cos;
            ovf_sin <= ovf_sin | upd_wrap_sin;
         end
      end
   end

   // ---------------------------------------------------------------------
   // Readout of the frozen bank
   // ---------------------------------------------------------------------
   assign send    = rd_active & (credit_cnt != '0);
   // Untouched frozen slot reads as zero
   assign rd_word = fresh[idle_bank][rd_slot] ? '0 : acc_mem[idle_bank][rd_slot];

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         rd_active  <= 1'b0;
         rd_slot    <= '0;
         vis_valid  <= 1'b0;
         credit_cnt <= credit_t'(`CORR_CREDITS);
      end else begin
         vis_valid <= send;
         if (take) begin
            rd_active <= 1'b1;
            rd_slot   <= '0;
         end else if (send) begin
            rd_active <= (rd_slot != LAST_SLOT);
            rd_slot   <= slot_t'(rd_slot + 1'b1);
         end
         // One credit out per send, one back per return pulse
         case ({send, vis_credit})
            2'b10:   credit_cnt <= credit_t'(credit_cnt - 1'b1);
            2'b01:   credit_cnt <= credit_t'(credit_cnt + 1'b1);
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   always_ff @(posedge clk_x) begin
      if (send) begin
         vis_slot <= rd_slot;
         vis_data <= rd_word;
      end
   end

endmodule

// File: verilog/tart_correlator.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module tart_correlator (
   input  logic                      clk_x,
   input  logic                      rst_n,
   input  logic                      sample_valid,
   output logic                      sample_ready,
   input  logic [`CORR_ANTENNAS-1:0] sample_re,
   input  logic [`CORR_ANTENNAS-1:0] sample_im,
   input  logic                      bank_switch,
   input  logic                      vis_credit,
   output logic                      vis_valid,
   output corr_pkg::slot_t           vis_slot,
   output corr_pkg::vis_t            vis_data,
   output logic                      vis_overflow_cos,
   output logic                      vis_overflow_sin
);
   import corr_pkg::*;

   // Decode to execute
   logic  step_valid;
   slot_t step_slot;
   logic  step_ar;
   logic  step_br;
   logic  step_bi;

   // Execute and result loop
   vis_t  prior_data;
   logic  prior_fresh;
   logic  upd_valid;
   slot_t upd_slot;
   vis_t  upd_data;
   logic  upd_wrap_cos;
   logic  upd_wrap_sin;

   logic  hold;
   logic  pipe_busy;

   // Ready low without hold means the walker is mid-sample
   // With hold up, a walk in progress always shows a step or update valid
   assign pipe_busy = (~sample_ready & ~hold) | step_valid | upd_valid;

   // ---------------------------------------------------------------------
   // Pipeline
   // ---------------------------------------------------------------------
   pair_decode u_decode (.*);

   correlate_execute u_execute (.*);

   visibility_result u_result (.*);

endmodule

// File: testbench/tart_correlator_assertions.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module tart_correlator_assertions (
   input logic              clk_x,
   input logic              rst_n,
   input logic              sample_ready,
   input logic              vis_valid,
   input logic              vis_credit,
   input logic              switch_pend,
   input corr_pkg::credit_t credit_cnt
);
   import corr_pkg::*;

   // Words delivered and not yet paid back, seen from the ports
   int unpaid;

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n)
         unpaid <= 0;
      else
         unpaid <= unpaid + int'(vis_valid) - int'(vis_credit);
   end

   // A new word needs a credit the consumer has granted
   assert property (@(posedge clk_x) disable iff (!rst_n)
      vis_valid |-> unpaid < `CORR_CREDITS)
      else $error("vis_valid raised with no credit held");

   // Walker blocked while a switch waits
   assert property (@(posedge clk_x) disable iff (!rst_n)
      switch_pend |-> !sample_ready)
      else $error("sample_ready high with a bank switch pending");

   assert property (@(posedge clk_x) disable iff (!rst_n)
      credit_cnt <= credit_t'(`CORR_CREDITS))
      else $error("credit count above the credit limit");

endmodule

bind tart_correlator tart_correlator_assertions u_assert (
   .clk_x        (clk_x),
   .rst_n        (rst_n),
   .sample_ready (sample_ready),
   .vis_valid    (vis_valid),
   .vis_credit   (vis_credit),
   .switch_pend  (u_result.switch_pend),
   .credit_cnt   (u_result.credit_cnt)
);

// File: testbench/tb_tart_correlator.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module tb_tart_correlator;
   import corr_pkg::*;

   typedef logic [`CORR_ANTENNAS-1:0] lanes_t;

   localparam int PAIR_W = $bits(pair_t);
   localparam logic [PAIR_W*`CORR_SLOTS-1:0] PAIR_TABLE = `CORR_PAIR_TABLE;
   localparam int ACC_MAX = (1 << (`CORR_ACCUM_BITS - 1)) - 1;
   localparam int ACC_MIN = -(1 << (`CORR_ACCUM_BITS - 1));

   // Run length, all phases together
   localparam int N_SAMPLES   = 40 + 10 + 5 + 30 + 2048 + 3 + 20;
   localparam int N_SWITCHES  = 10;
   localparam int CYCLE_LIMIT = N_SAMPLES * `CORR_SLOTS + N_SWITCHES * 40 + 4000;

   logic   clk_x = 1'b0;
   logic   rst_n;
   logic   sample_valid;
   logic   sample_ready;
   lanes_t sample_re;
   lanes_t sample_im;
   logic   bank_switch;
   logic   vis_credit;
   logic   vis_valid;
   slot_t  vis_slot;
   vis_t   vis_data;
   logic   vis_overflow_cos;
   logic   vis_overflow_sin;

   integer seed        = 32'h1ffba3ed;
   int     cycle_cnt   = 0;
   int     owed        = 0;
   int     credit_rate = 8;
   string  test_name   = "reset";

   // Reference model, two banks plus the active-bank flags
   vis_t  m_bank  [2][`CORR_SLOTS];
   logic  m_fresh [2][`CORR_SLOTS];
   bit    m_act;
   logic  m_ovf_cos;
   logic  m_ovf_sin;

   // Expected readout stream
   vis_t  exp_vis  [$];
   slot_t exp_slot [$];
   logic  exp_ocos [$];
   logic  exp_osin [$];

   tart_correlator dut0 (.*);

   always #4 clk_x = ~clk_x;

   // ---------------------------------------------------------------------
   // Error reporting and compares
   // ---------------------------------------------------------------------
   task automatic abort_run();
      $display("TEST FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_vis(input string name, input vis_t exp, input vis_t act);
      if (act !== exp) begin
         $display("FAIL %s: expected cos %0d sin %0d, actual cos %0d sin %0d",
                  name, exp.cos_acc, exp.sin_acc, act.cos_acc, act.sin_acc);
         abort_run();
      end
   endtask

   task automatic check_slot(input string name, input slot_t exp, input slot_t act);
      if (act !== exp) begin
         $display("FAIL %s: expected slot %0d, actual slot %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   // ---------------------------------------------------------------------
   // Model updates
   // ---------------------------------------------------------------------
   // One accepted sample, every pair of the table
   function automatic void apply_sample(input lanes_t re, input lanes_t im);
      pair_t p;
      int    base_cos;
      int    base_sin;
      int    sum_cos;
      int    sum_sin;
      for (int s = 0; s < `CORR_SLOTS; s++) begin
         p = PAIR_TABLE[s*PAIR_W +: PAIR_W];
         base_cos = m_fresh[m_act][s] ? 0 : int'(m_bank[m_act][s].cos_acc);
         base_sin = m_fresh[m_act][s] ? 0 : int'(m_bank[m_act][s].sin_acc);
         sum_cos  = base_cos + ((re[p.a] == re[p.b]) ? 1 : -1);
         sum_sin  = base_sin + ((re[p.a] == im[p.b]) ? 1 : -1);
         // Out of signed range means the counter wrapped
         if (sum_cos > ACC_MAX || sum_cos < ACC_MIN)
            m_ovf_cos = 1'b1;
         if (sum_sin > ACC_MAX || sum_sin < ACC_MIN)
            m_ovf_sin = 1'b1;
         m_bank[m_act][s].cos_acc = accum_t'(sum_cos);
         m_bank[m_act][s].sin_acc = accum_t'(sum_sin);
         m_fresh[m_act][s] = 1'b0;
      end
   endfunction

   // Freeze the active bank and queue its readout
   function automatic void apply_switch();
      vis_t word;
      for (int s = 0; s < `CORR_SLOTS; s++) begin
         word = m_fresh[m_act][s] ? vis_t'(0) : m_bank[m_act][s];
         exp_vis.push_back(word);
         exp_slot.push_back(slot_t'(s));
         exp_ocos.push_back(m_ovf_cos);
         exp_osin.push_back(m_ovf_sin);
      end
      m_act = !m_act;
      for (int s = 0; s < `CORR_SLOTS; s++)
         m_fresh[m_act][s] = 1'b1;
      m_ovf_cos = 1'b0;
      m_ovf_sin = 1'b0;
   endfunction

   // ---------------------------------------------------------------------
   // Stimulus tasks
   // ---------------------------------------------------------------------
   // Random gaps unless all-agree samples are wanted
   // All-agree samples run back to back with no switch around
   task automatic drive_samples(input int count, input logic agree_all);
      int   taken_cnt;
      int   since_accept;
      logic fire;
      taken_cnt    = 0;
      since_accept = 0;
      while (taken_cnt < count) begin
         @(posedge clk_x);
         fire = sample_valid & sample_ready;
         // Ready back only for the last slot of the walk
         if (agree_all && taken_cnt > 0) begin
            since_accept++;
            check_flag({test_name, " sample_ready"}, since_accept == `CORR_SLOTS,
                       sample_ready);
         end
         if (fire) begin
            apply_sample(sample_re, sample_im);
            taken_cnt++;
            since_accept = 0;
         end
         if (fire || !sample_valid) begin
            if (taken_cnt < count && (agree_all || ($random(seed) & 3) != 0)) begin
               sample_valid <= 1'b1;
               sample_re    <= agree_all ? '1 : lanes_t'($random(seed));
               sample_im    <= agree_all ? '1 : lanes_t'($random(seed));
            end else begin
               sample_valid <= 1'b0;
            end
         end
      end
   endtask

   // Request pulse, then wait until ready shows the switch was taken
   task automatic switch_banks();
      @(posedge clk_x);
      bank_switch <= 1'b1;
      @(posedge clk_x);
      bank_switch <= 1'b0;
      apply_switch();
      @(posedge clk_x);
      while (!sample_ready)
         @(posedge clk_x);
   endtask

   task automatic wait_readout();
      while (exp_vis.size() != 0)
         @(posedge clk_x);
   endtask

   // ---------------------------------------------------------------------
   // Consumer side
   // ---------------------------------------------------------------------
   // Credit back only for words already received
   always @(posedge clk_x) begin
      if (!rst_n) begin
         owed = 0;
         vis_credit <= 1'b0;
      end else begin
         if (vis_valid)
            owed++;
         if (owed > 0 && ($random(seed) & 7) < credit_rate) begin
            vis_credit <= 1'b1;
            owed--;
         end else begin
            vis_credit <= 1'b0;
         end
      end
   end

   // Readout compare, mid-cycle
   always @(negedge clk_x) begin
      if (rst_n && vis_valid) begin
         if (exp_vis.size() == 0) begin
            $display("Visibility sent with no readout expected, slot %0d", vis_slot);
            abort_run();
         end
         check_slot(test_name, exp_slot.pop_front(), vis_slot);
         check_vis(test_name, exp_vis.pop_front(), vis_data);
         check_flag({test_name, " overflow_cos"}, exp_ocos.pop_front(), vis_overflow_cos);
         check_flag({test_name, " overflow_sin"}, exp_osin.pop_front(), vis_overflow_sin);
      end
   end

   always @(posedge clk_x) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   // ---------------------------------------------------------------------
   // Test sequence
   // ---------------------------------------------------------------------
   initial begin
      rst_n        = 1'b0;
      sample_valid = 1'b0;
      sample_re    = '0;
      sample_im    = '0;
      bank_switch  = 1'b0;
      vis_credit   = 1'b0;
      m_act        = 1'b0;
      m_ovf_cos    = 1'b0;
      m_ovf_sin    = 1'b0;
      for (int s = 0; s < `CORR_SLOTS; s++) begin
         m_fresh[0][s] = 1'b1;
         m_fresh[1][s] = 1'b1;
         m_bank[0][s]  = '0;
         m_bank[1][s]  = '0;
      end
      repeat (10) @(posedge clk_x);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk_x);

      test_name = "accumulate";
      drive_samples(40, 1'b0);
      switch_banks();
      wait_readout();

      // Empty bank first, then two short runs
      test_name = "clear";
      switch_banks();
      wait_readout();
      drive_samples(10, 1'b0);
      switch_banks();
      drive_samples(5, 1'b0);
      switch_banks();
      wait_readout();

      // Slow credits, second switch lands mid-readout
      test_name   = "credit";
      credit_rate = 2;
      drive_samples(30, 1'b0);
      switch_banks();
      switch_banks();
      wait_readout();
      credit_rate = 8;

      // 2048 all-agree samples wrap both counters
      test_name = "overflow";
      drive_samples(2048, 1'b1);
      switch_banks();
      drive_samples(3, 1'b0);
      switch_banks();
      wait_readout();

      // Switch while the walker is busy
      test_name   = "busy_switch";
      credit_rate = 3;
      fork
         drive_samples(20, 1'b0);
         begin
            repeat (40) @(posedge clk_x);
            switch_banks();
         end
      join
      switch_banks();
      wait_readout();
      credit_rate = 8;

      repeat (30) @(posedge clk_x);
      if (exp_vis.size() != 0) begin
         $display("Readout incomplete, %0d visibilities never arrived", exp_vis.size());
         abort_run();
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

// File: project.f
+incdir+verilog
verilog/corr_pkg.sv
verilog/pair_decode.sv
verilog/correlate_execute.sv
verilog/visibility_result.sv
verilog/tart_correlator.sv
testbench/tart_correlator_assertions.sv
testbench/tb_tart_correlator.sv

// File: Bender.yml
package:
  name: tart_correlator

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/corr_pkg.sv
      - verilog/pair_decode.sv
      - verilog/correlate_execute.sv
      - verilog/visibility_result.sv
      - verilog/tart_correlator.sv
  - target: test
    files:
      - testbench/tart_correlator_assertions.sv
      - testbench/tb_tart_correlator.sv
